// File: src/scrambler_macros.svh
`ifndef SCRAMBLER_MACROS_SVH
`define SCRAMBLER_MACROS_SVH

// data path of one lane, one PIPE word per clock
`define SCR_DATA_W 32
`define SCR_BYTES 4

// Gen1/Gen2 scrambler, x^16+x^5+x^4+x^3+1
`define SCR_G1_LFSR_W 16
`define SCR_G1_SEED {`SCR_G1_LFSR_W{1'b1}}

// Gen3+ scrambler, x^23+x^21+x^16+x^8+x^5+x^2+1, seeded per lane
`define SCR_G3_LFSR_W 23

`endif

// File: src/pcie_phy_pkg.sv
`default_nettype none

`include "scrambler_macros.svh"

package pcie_phy_pkg;

  // link data rate, anything below gen3 runs the 8b/10b scrambler
  typedef enum logic [2:0] {
    gen1,
    gen2,
    gen3,
    gen4,
    gen5
  } rate_speed_e;

  // pipe_width_i codes, low bytes are active first
  localparam logic [5:0] PIPE_W8  = 6'd8;
  localparam logic [5:0] PIPE_W16 = 6'd16;
  localparam logic [5:0] PIPE_W32 = 6'd32;

  // byte enables for a given PIPE width, unknown codes use the full word
  function automatic logic [`SCR_BYTES-1:0] pipe_byte_en(input logic [5:0] width);
    case (width)
      PIPE_W8:  return 4'b0001;
      PIPE_W16: return 4'b0011;
      PIPE_W32: return 4'b1111;
      default:  return 4'b1111;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: src/pcie_symbol_pkg.sv
`default_nettype none

`include "scrambler_macros.svh"

package pcie_symbol_pkg;

  // 8b/10b control characters that change the scrambler
  localparam logic [7:0] K_COM = 8'hBC;
  localparam logic [7:0] K_SKP = 8'h1C;

  // 128b/130b sync headers
  localparam logic [1:0] SH_DATA = 2'b10;
  localparam logic [1:0] SH_OS   = 2'b01;

  // first symbol of an electrical idle exit ordered set
  localparam logic [7:0] EIEOS_SYM0 = 8'h00;

  // the seed repeats every eight lanes
  function automatic logic [`SCR_G3_LFSR_W-1:0] lane_seed(input logic [7:0] lane);
    case (lane[2:0])
      3'd0: return 23'h1DBFBC;
      3'd1: return 23'h0607BB;
      3'd2: return 23'h1EC760;
      3'd3: return 23'h18C0DB;
      3'd4: return 23'h010F12;
      3'd5: return 23'h19CFC9;
      3'd6: return 23'h0277CE;
      3'd7: return 23'h1BB807;
      default: return 23'h1DBFBC;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: src/gen1_scramble.sv
`timescale 1ns/1ps
`default_nettype none

`include "scrambler_macros.svh"

module gen1_scramble (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic [`SCR_DATA_W-1:0]  data_in_i,
  input  wire logic                    data_valid_i,
  input  wire logic [`SCR_BYTES-1:0]   data_k_in_i,
  input  wire logic [5:0]              pipe_width_i,
  output logic      [`SCR_DATA_W-1:0]  data_out_o
);

  localparam int byte_w = `SCR_DATA_W / `SCR_BYTES;

  logic [`SCR_G1_LFSR_W-1:0] lfsr_q;
  logic [`SCR_G1_LFSR_W-1:0] lfsr_d;
  logic [`SCR_DATA_W-1:0]    data_d;
  logic [`SCR_BYTES-1:0]     byte_en;

  // one shift of the x^16+x^5+x^4+x^3+1 LFSR, the top bit feeds back
  function automatic logic [`SCR_G1_LFSR_W-1:0] lfsr_step(
    input logic [`SCR_G1_LFSR_W-1:0] s
  );
    logic [`SCR_G1_LFSR_W-1:0] n;
    logic                      fb;
    fb   = s[`SCR_G1_LFSR_W-1];
    n    = {s[`SCR_G1_LFSR_W-2:0], fb};
    n[3] = s[2] ^ fb;
    n[4] = s[3] ^ fb;
    n[5] = s[4] ^ fb;
    return n;
  endfunction

  // eight keystream bits, bit 0 of the byte goes first
  function automatic logic [byte_w-1:0] key_byte(
    input logic [`SCR_G1_LFSR_W-1:0] s
  );
    logic [`SCR_G1_LFSR_W-1:0] t;
    logic [byte_w-1:0]         k;
    t = s;
    for (int i = 0; i < byte_w; i++) begin
      k[i] = t[`SCR_G1_LFSR_W-1];
      t    = lfsr_step(t);
    end
    return k;
  endfunction

  function automatic logic [`SCR_G1_LFSR_W-1:0] adv_byte(
    input logic [`SCR_G1_LFSR_W-1:0] s
  );
    logic [`SCR_G1_LFSR_W-1:0] t;
    t = s;
    for (int i = 0; i < byte_w; i++) begin
      t = lfsr_step(t);
    end
    return t;
  endfunction

  assign byte_en = pcie_phy_pkg::pipe_byte_en(pipe_width_i);

  // walk the active bytes from byte 0 and carry the LFSR state along
  always_comb begin
    logic [`SCR_G1_LFSR_W-1:0] s;
    logic [byte_w-1:0]         din;
    s      = lfsr_q;
    data_d = '0;
    for (int b = 0; b < `SCR_BYTES; b++) begin
      din = data_in_i[b*byte_w +: byte_w];
      if (byte_en[b]) begin
        if (!data_k_in_i[b]) begin
          data_d[b*byte_w +: byte_w] = din ^ key_byte(s);
          s = adv_byte(s);
        end else if (din == pcie_symbol_pkg::K_COM) begin
          data_d[b*byte_w +: byte_w] = din;
          s = `SCR_G1_SEED;  // the symbol after COM starts from the seed
        end else begin
          data_d[b*byte_w +: byte_w] = din;
          if (din != pcie_symbol_pkg::K_SKP) begin
            s = adv_byte(s);  // SKP does not clock the LFSR
          end
        end
      end
    end
    lfsr_d = s;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q     <= `SCR_G1_SEED;
      data_out_o <= '0;
    end else if (data_valid_i) begin
      lfsr_q     <= lfsr_d;
      data_out_o <= data_d;
    end
  end

endmodule

`default_nettype wire

// File: src/gen3_scramble.sv
`timescale 1ns/1ps
`default_nettype none

`include "scrambler_macros.svh"

module gen3_scramble (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic [7:0]              lane_number_i,
  input  wire logic [1:0]              sync_header_i,
  input  wire logic                    block_start_i,
  input  wire logic [`SCR_DATA_W-1:0]  data_in_i,
  input  wire logic                    data_valid_i,
  input  wire logic [5:0]              pipe_width_i,
  output logic      [`SCR_DATA_W-1:0]  data_out_o
);

  localparam int byte_w = `SCR_DATA_W / `SCR_BYTES;

  // Galois taps of x^23+x^21+x^16+x^8+x^5+x^2+1 without the x^23 term
  localparam logic [`SCR_G3_LFSR_W-1:0] taps = 23'h210125;

  logic [`SCR_G3_LFSR_W-1:0] lfsr_q;
  logic [`SCR_G3_LFSR_W-1:0] lfsr_d;
  logic [`SCR_G3_LFSR_W-1:0] seed;
  logic [`SCR_DATA_W-1:0]    data_d;
  logic [`SCR_BYTES-1:0]     byte_en;
  logic [1:0]                hdr_q;
  logic [1:0]                cur_hdr;
  logic                      is_data;
  logic                      eieos;

  function automatic logic [`SCR_G3_LFSR_W-1:0] lfsr_step(
    input logic [`SCR_G3_LFSR_W-1:0] s
  );
    logic [`SCR_G3_LFSR_W-1:0] n;
    n = {s[`SCR_G3_LFSR_W-2:0], 1'b0};
    if (s[`SCR_G3_LFSR_W-1]) begin
      n = n ^ taps;
    end
    return n;
  endfunction

  // keystream for one byte, bit 0 first
  function automatic logic [byte_w-1:0] key_byte(
    input logic [`SCR_G3_LFSR_W-1:0] s
  );
    logic [`SCR_G3_LFSR_W-1:0] t;
    logic [byte_w-1:0]         k;
    t = s;
    for (int i = 0; i < byte_w; i++) begin
      k[i] = t[`SCR_G3_LFSR_W-1];
      t    = lfsr_step(t);
    end
    return k;
  endfunction

  function automatic logic [`SCR_G3_LFSR_W-1:0] adv_byte(
    input logic [`SCR_G3_LFSR_W-1:0] s
  );
    logic [`SCR_G3_LFSR_W-1:0] t;
    t = s;
    for (int i = 0; i < byte_w; i++) begin
      t = lfsr_step(t);
    end
    return t;
  endfunction

  assign byte_en = pcie_phy_pkg::pipe_byte_en(pipe_width_i);
  assign seed    = pcie_symbol_pkg::lane_seed(lane_number_i);

  // the first word of a block carries its own header, later words use the latched one
  assign cur_hdr = block_start_i ? sync_header_i : hdr_q;
  assign is_data = (cur_hdr == pcie_symbol_pkg::SH_DATA);

  assign eieos = block_start_i && (sync_header_i == pcie_symbol_pkg::SH_OS) &&
                 byte_en[0] && (data_in_i[byte_w-1:0] == pcie_symbol_pkg::EIEOS_SYM0);

  always_comb begin
    logic [`SCR_G3_LFSR_W-1:0] s;
    logic [byte_w-1:0]         din;
    s      = lfsr_q;
    data_d = '0;
    for (int b = 0; b < `SCR_BYTES; b++) begin
      din = data_in_i[b*byte_w +: byte_w];
      if (byte_en[b]) begin
        if (is_data) begin
          data_d[b*byte_w +: byte_w] = din ^ key_byte(s);
          s = adv_byte(s);
        end else begin
          data_d[b*byte_w +: byte_w] = din;  // ordered sets go out in the clear
        end
      end
    end
    lfsr_d = eieos ? seed : s;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q     <= seed;
      hdr_q      <= '0;
      data_out_o <= '0;
    end else if (data_valid_i) begin
      lfsr_q     <= lfsr_d;
      data_out_o <= data_d;
      if (block_start_i) begin
        hdr_q <= sync_header_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/scrambler.sv
`timescale 1ns/1ps
`default_nettype none

`include "scrambler_macros.svh"

module scrambler (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  input  wire logic [7:0]                  lane_number_i,
  input  wire logic [1:0]                  sync_header_i,
  input  wire pcie_phy_pkg::rate_speed_e   curr_data_rate_i,
  input  wire logic [`SCR_DATA_W-1:0]      data_in_i,
  input  wire logic                        block_start_i,
  input  wire logic                        data_valid_i,
  input  wire logic [`SCR_BYTES-1:0]       data_k_in_i,
  input  wire logic [5:0]                  pipe_width_i,
  output logic                             data_valid_o,
  output logic      [`SCR_DATA_W-1:0]      data_out_o,
  output logic      [`SCR_BYTES-1:0]       data_k_out_o,
  output logic      [1:0]                  sync_header_o,
  output logic                             block_start_o
);

  logic [`SCR_DATA_W-1:0] gen1_data;
  logic [`SCR_DATA_W-1:0] gen3_data;

  // both scramblers always run so a rate change finds its LFSR already in step
  gen1_scramble u_gen1_scramble (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .data_in_i    (data_in_i),
    .data_valid_i (data_valid_i),
    .data_k_in_i  (data_k_in_i),
    .pipe_width_i (pipe_width_i),
    .data_out_o   (gen1_data)
  );

  gen3_scramble u_gen3_scramble (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lane_number_i (lane_number_i),
    .sync_header_i (sync_header_i),
    .block_start_i (block_start_i),
    .data_in_i     (data_in_i),
    .data_valid_i  (data_valid_i),
    .pipe_width_i  (pipe_width_i),
    .data_out_o    (gen3_data)
  );

  // side-band delay matches the one register stage inside the scramblers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_valid_o  <= 1'b0;
      data_k_out_o  <= '0;
      sync_header_o <= '0;
      block_start_o <= 1'b0;
    end else begin
      data_valid_o  <= data_valid_i;
      data_k_out_o  <= data_k_in_i;
      sync_header_o <= sync_header_i;
      block_start_o <= block_start_i;
    end
  end

  always_comb begin
    if (curr_data_rate_i < pcie_phy_pkg::gen3) begin
      data_out_o = gen1_data;
    end else begin
      data_out_o = gen3_data;  // 128b/130b rates
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_scrambler.sv
`timescale 1ns/1ps
`default_nettype none

`include "scrambler_macros.svh"

module tb_scrambler;

  localparam int BLK_DATA  = 0;
  localparam int BLK_OS    = 1;
  localparam int BLK_EIEOS = 2;
  localparam int GAP_MAX   = 2;

  // stimulus length per test, in clock cycles
  localparam int RESET_CYC   = 6;
  localparam int N_RESETS    = 9;
  localparam int T1_WORDS    = 64;
  localparam int T2_WORDS    = 96;
  localparam int T3_G1_WORDS = 80;
  localparam int T3_G3_WORDS = 56;
  localparam int T4_WORDS    = 72;
  localparam int T5_G1_WORDS = 48;
  localparam int T5_G3_WORDS = 32;
  localparam int STIM_CYCLES = N_RESETS * RESET_CYC + T1_WORDS + T2_WORDS + T3_G1_WORDS +
                               T3_G3_WORDS + T4_WORDS +
                               (T5_G1_WORDS + T5_G3_WORDS) * (GAP_MAX + 1) + 4;
  localparam int TIMEOUT_CYCLES = STIM_CYCLES * 3 / 2 + 100;

  // Galois taps taken from the polynomials, the top term is the shifted-out bit
  localparam logic [`SCR_G1_LFSR_W-1:0] G1_TAPS = (16'd1 << 5) | (16'd1 << 4) |
                                                  (16'd1 << 3) | 16'd1;
  localparam logic [`SCR_G3_LFSR_W-1:0] G3_TAPS = (23'd1 << 21) | (23'd1 << 16) | (23'd1 << 8) |
                                                  (23'd1 << 5) | (23'd1 << 2) | 23'd1;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic [3:0]  k;
    logic [1:0]  sh;
    logic        bs;
  } exp_t;

  logic                      clk_i;
  logic                      rst_i;
  logic [7:0]                lane_number_i;
  logic [1:0]                sync_header_i;
  pcie_phy_pkg::rate_speed_e curr_data_rate_i;
  logic [`SCR_DATA_W-1:0]    data_in_i;
  logic                      block_start_i;
  logic                      data_valid_i;
  logic [`SCR_BYTES-1:0]     data_k_in_i;
  logic [5:0]                pipe_width_i;
  logic                      data_valid_o;
  logic [`SCR_DATA_W-1:0]    data_out_o;
  logic [`SCR_BYTES-1:0]     data_k_out_o;
  logic [1:0]                sync_header_o;
  logic                      block_start_o;

  logic [`SCR_G1_LFSR_W-1:0] g1_lfsr;
  logic [`SCR_G3_LFSR_W-1:0] g3_lfsr;
  logic [1:0]                g3_hdr;
  logic [7:0]                lane;
  pcie_phy_pkg::rate_speed_e rate;
  exp_t                      pend_q[$];
  exp_t                      prev;
  bit                        have_prev;
  int                        cycle_cnt;

  scrambler UUT (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .lane_number_i    (lane_number_i),
    .sync_header_i    (sync_header_i),
    .curr_data_rate_i (curr_data_rate_i),
    .data_in_i        (data_in_i),
    .block_start_i    (block_start_i),
    .data_valid_i     (data_valid_i),
    .data_k_in_i      (data_k_in_i),
    .pipe_width_i     (pipe_width_i),
    .data_valid_o     (data_valid_o),
    .data_out_o       (data_out_o),
    .data_k_out_o     (data_k_out_o),
    .sync_header_o    (sync_header_o),
    .block_start_o    (block_start_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp_v);
    if (got !== exp_v) begin
      $display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp_v, $time);
      $display("Done: errors found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic int active_bytes(input logic [5:0] width);
    case (width)
      pcie_phy_pkg::PIPE_W8:  return 1;
      pcie_phy_pkg::PIPE_W16: return 2;
      default:                return 4;
    endcase
  endfunction

  function automatic logic [`SCR_G1_LFSR_W-1:0] g1_next(input logic [`SCR_G1_LFSR_W-1:0] s);
    return {s[`SCR_G1_LFSR_W-2:0], 1'b0} ^ (s[`SCR_G1_LFSR_W-1] ? G1_TAPS : '0);
  endfunction

  function automatic logic [`SCR_G3_LFSR_W-1:0] g3_next(input logic [`SCR_G3_LFSR_W-1:0] s);
    return {s[`SCR_G3_LFSR_W-2:0], 1'b0} ^ (s[`SCR_G3_LFSR_W-1] ? G3_TAPS : '0);
  endfunction

  // expected 8b/10b-rate word, COM reseeds, SKP holds, other K advances
  function automatic logic [31:0] gen1_ref(input logic [31:0] data, input logic [3:0] k,
                                           input logic [5:0] width);
    logic [31:0] res;
    logic [7:0]  d;
    int          b;
    int          i;
    res = '0;
    for (b = 0; b < active_bytes(width); b++) begin
      d = data[b*8 +: 8];
      res[b*8 +: 8] = d;
      if (k[b] && d == pcie_symbol_pkg::K_COM) begin
        g1_lfsr = `SCR_G1_SEED;
      end else if (!(k[b] && d == pcie_symbol_pkg::K_SKP)) begin
        for (i = 0; i < 8; i++) begin
          if (!k[b]) res[b*8+i] = d[i] ^ g1_lfsr[`SCR_G1_LFSR_W-1];
          g1_lfsr = g1_next(g1_lfsr);
        end
      end
    end
    return res;
  endfunction

  // expected 128b/130b-rate word, only data blocks scramble and advance
  function automatic logic [31:0] gen3_ref(input logic [31:0] data, input logic [5:0] width,
                                           input logic [1:0] sh, input logic bs);
    logic [31:0] res;
    int          b;
    int          i;
    res = '0;
    if (bs) g3_hdr = sh;
    for (b = 0; b < active_bytes(width); b++) begin
      res[b*8 +: 8] = data[b*8 +: 8];
      if (g3_hdr == pcie_symbol_pkg::SH_DATA) begin
        for (i = 0; i < 8; i++) begin
          res[b*8+i] = data[b*8+i] ^ g3_lfsr[`SCR_G3_LFSR_W-1];
          g3_lfsr = g3_next(g3_lfsr);
        end
      end
    end
    if (bs && sh == pcie_symbol_pkg::SH_OS && data[7:0] == pcie_symbol_pkg::EIEOS_SYM0) begin
      g3_lfsr = pcie_symbol_pkg::lane_seed(lane);
    end
    return res;
  endfunction

  function automatic logic [7:0] pick_k();
    case ($urandom % 6)
      0:       return pcie_symbol_pkg::K_COM;
      1:       return pcie_symbol_pkg::K_SKP;
      2:       return 8'hF7;
      3:       return 8'hFB;
      4:       return 8'hFD;
      default: return 8'h7C;
    endcase
  endfunction

  task automatic drive_word(input logic [31:0] data, input logic [3:0] k, input logic [5:0] width,
                            input logic [1:0] sh, input logic bs);
    exp_t        e;
    logic [31:0] g1;
    logic [31:0] g3;
    @(posedge clk_i);
    data_in_i     <= data;
    data_k_in_i   <= k;
    pipe_width_i  <= width;
    sync_header_i <= sh;
    block_start_i <= bs;
    data_valid_i  <= 1'b1;
    g1 = gen1_ref(data, k, width);  // both paths track every word
    g3 = gen3_ref(data, width, sh, bs);
    e.valid = 1'b1;
    e.data  = (rate < pcie_phy_pkg::gen3) ? g1 : g3;
    e.k     = k;
    e.sh    = sh;
    e.bs    = bs;
    pend_q.push_back(e);
  endtask

  task automatic drive_idle(input int n);
    exp_t e;
    int   i;
    for (i = 0; i < n; i++) begin
      @(posedge clk_i);
      data_in_i     <= $urandom;  // junk that must be ignored
      data_k_in_i   <= 4'($urandom);
      block_start_i <= 1'b0;
      data_valid_i  <= 1'b0;
      e = '0;
      pend_q.push_back(e);
    end
  endtask

  task automatic apply_reset(input logic [7:0] ln, input pcie_phy_pkg::rate_speed_e r);
    @(posedge clk_i);
    rst_i         <= 1'b1;
    data_valid_i  <= 1'b0;
    block_start_i <= 1'b0;
    // the last word of the previous test still leaves under the old rate
    @(posedge clk_i);
    lane_number_i    <= ln;
    curr_data_rate_i <= r;
    lane = ln;
    rate = r;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    g1_lfsr = `SCR_G1_SEED;
    g3_lfsr = pcie_symbol_pkg::lane_seed(ln);
    g3_hdr  = 2'b00;
    @(negedge clk_i);
    check_val("data_valid_o", data_valid_o, 0);
    check_val("block_start_o", block_start_o, 0);
    check_val("data_k_out_o", data_k_out_o, 0);
    check_val("sync_header_o", sync_header_o, 0);
    check_val("data_out_o", data_out_o, 0);
  endtask

  task automatic send_gen1_words(input int n, input logic [5:0] width, input bit with_k,
                                 input bit gaps);
    logic [31:0] w;
    logic [3:0]  k;
    int          i;
    int          b;
    for (i = 0; i < n; i++) begin
      if (gaps) drive_idle($urandom % (GAP_MAX + 1));
      w = $urandom;
      k = '0;
      for (b = 0; b < 4; b++) begin
        if (with_k && ($urandom % 4 == 0)) begin
          k[b]       = 1'b1;
          w[b*8 +: 8] = pick_k();
        end
      end
      drive_word(w, k, width, 2'b00, 1'b0);
    end
  endtask

  // one 130-bit block, 16 symbols spread over as many words as the width needs
  task automatic send_block(input int kind, input logic [5:0] width, input bit gaps);
    logic [31:0] w;
    logic [1:0]  sh;
    int          n_words;
    int          i;
    n_words = 16 / active_bytes(width);
    sh = (kind == BLK_DATA) ? pcie_symbol_pkg::SH_DATA : pcie_symbol_pkg::SH_OS;
    for (i = 0; i < n_words; i++) begin
      if (gaps) drive_idle($urandom % (GAP_MAX + 1));
      w = (kind == BLK_EIEOS) ? 32'hFF00FF00 : $urandom;
      if (kind == BLK_OS && i == 0 && w[7:0] == pcie_symbol_pkg::EIEOS_SYM0) w[7:0] = 8'h2D;
      // the header only counts on the first word, so later words carry noise
      drive_word(w, 4'b0000, width, (i == 0) ? sh : 2'($urandom), i == 0);
    end
  endtask

  always @(negedge clk_i) begin
    if (have_prev) begin
      check_val("data_valid_o", data_valid_o, prev.valid);
      if (prev.valid) begin
        check_val("data_out_o", data_out_o, prev.data);
        check_val("data_k_out_o", data_k_out_o, prev.k);
        check_val("sync_header_o", sync_header_o, prev.sh);
        check_val("block_start_o", block_start_o, prev.bs);
      end
    end
    if (pend_q.size() > 0) begin
      prev      = pend_q.pop_front();
      have_prev = 1'b1;
    end else begin
      have_prev = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Simulation stopped because the tests did not finish in %0d cycles", cycle_cnt);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
  end

  initial begin
    void'($urandom(32'hd2cb));
    rst_i            = 1'b1;
    lane_number_i    = 8'd0;
    sync_header_i    = 2'b00;
    curr_data_rate_i = pcie_phy_pkg::gen1;
    data_in_i        = '0;
    block_start_i    = 1'b0;
    data_valid_i     = 1'b0;
    data_k_in_i      = '0;
    pipe_width_i     = pcie_phy_pkg::PIPE_W32;
    have_prev        = 1'b0;
    cycle_cnt        = 0;
    lane             = 8'd0;
    rate             = pcie_phy_pkg::gen1;

    apply_reset(8'd0, pcie_phy_pkg::gen1);
    send_gen1_words(T1_WORDS, pcie_phy_pkg::PIPE_W32, 1'b0, 1'b0);

    apply_reset(8'd0, pcie_phy_pkg::gen2);
    drive_word({{3{pcie_symbol_pkg::K_SKP}}, pcie_symbol_pkg::K_COM}, 4'hF,
               pcie_phy_pkg::PIPE_W32, 2'b00, 1'b0);
    drive_word({8'h12, 8'h34, pcie_symbol_pkg::K_COM, 8'h56}, 4'b0010,
               pcie_phy_pkg::PIPE_W32, 2'b00, 1'b0);
    send_gen1_words(T2_WORDS - 2, pcie_phy_pkg::PIPE_W32, 1'b1, 1'b0);

    apply_reset(8'd0, pcie_phy_pkg::gen1);
    send_gen1_words(32, pcie_phy_pkg::PIPE_W8, 1'b0, 1'b0);
    send_gen1_words(32, pcie_phy_pkg::PIPE_W16, 1'b0, 1'b0);
    send_gen1_words(16, pcie_phy_pkg::PIPE_W32, 1'b0, 1'b0);

    apply_reset(8'd0, pcie_phy_pkg::gen3);
    send_block(BLK_DATA, pcie_phy_pkg::PIPE_W8, 1'b0);
    send_block(BLK_DATA, pcie_phy_pkg::PIPE_W8, 1'b0);
    send_block(BLK_DATA, pcie_phy_pkg::PIPE_W16, 1'b0);
    send_block(BLK_OS, pcie_phy_pkg::PIPE_W16, 1'b0);
    send_block(BLK_DATA, pcie_phy_pkg::PIPE_W16, 1'b0);

    for (int t = 0; t < 3; t++) begin
      apply_reset((t == 0) ? 8'd0 : (t == 1) ? 8'd3 : 8'd7,
                  (t == 0) ? pcie_phy_pkg::gen3 :
                  (t == 1) ? pcie_phy_pkg::gen4 : pcie_phy_pkg::gen5);
      send_block(BLK_DATA, pcie_phy_pkg::PIPE_W32, 1'b0);
      send_block(BLK_DATA, pcie_phy_pkg::PIPE_W32, 1'b0);
      send_block(BLK_OS, pcie_phy_pkg::PIPE_W32, 1'b0);
      send_block(BLK_DATA, pcie_phy_pkg::PIPE_W32, 1'b0);
      send_block(BLK_EIEOS, pcie_phy_pkg::PIPE_W32, 1'b0);
      send_block(BLK_DATA, pcie_phy_pkg::PIPE_W32, 1'b0);  // restarts from the lane seed
    end

    apply_reset(8'd0, pcie_phy_pkg::gen1);
    send_gen1_words(T5_G1_WORDS, pcie_phy_pkg::PIPE_W32, 1'b1, 1'b1);

    apply_reset(8'd10, pcie_phy_pkg::gen3);  // lane 10 uses the seed of lane 2
    send_block(BLK_DATA, pcie_phy_pkg::PIPE_W32, 1'b1);
    send_block(BLK_OS, pcie_phy_pkg::PIPE_W32, 1'b1);
    send_block(BLK_DATA, pcie_phy_pkg::PIPE_W32, 1'b1);
    send_block(BLK_EIEOS, pcie_phy_pkg::PIPE_W32, 1'b1);
    send_block(BLK_DATA, pcie_phy_pkg::PIPE_W32, 1'b1);
    send_block(BLK_DATA, pcie_phy_pkg::PIPE_W32, 1'b1);
    send_block(BLK_OS, pcie_phy_pkg::PIPE_W32, 1'b1);
    send_block(BLK_DATA, pcie_phy_pkg::PIPE_W32, 1'b1);

    drive_idle(2);
    repeat (2) @(negedge clk_i);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+src
src/pcie_phy_pkg.sv
src/pcie_symbol_pkg.sv
src/gen1_scramble.sv
src/gen3_scramble.sv
src/scrambler.sv
verification/tb_scrambler.sv

// File: Bender.yml
package:
  name: pcie_scrambler

sources:
  - include_dirs:
      - src
    files:
      - src/pcie_phy_pkg.sv
      - src/pcie_symbol_pkg.sv
      - src/gen1_scramble.sv
      - src/gen3_scramble.sv
      - src/scrambler.sv

  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_scrambler.sv
